// File: rtl/wb_pkg.sv
package wb_pkg;

    // master request, held stable until ack or err
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
        logic        cyc;
        logic        stb;
    } wb_req_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
        logic        err;
    } wb_rsp_t;

    localparam int NUM_SLAVES = 3;
    localparam int SLV_DMEM   = 0;
    localparam int SLV_GPIO   = 1;
    localparam int SLV_CLINT  = 2;

    // address map
    localparam logic [31:0] DMEM_BASE  = 32'h8000_0000;
    localparam logic [31:0] DMEM_MASK  = 32'hfffc_0000;
    localparam logic [31:0] GPIO_BASE  = 32'h2000_0100;
    localparam logic [31:0] GPIO_MASK  = 32'hffff_ff00;
    localparam logic [31:0] CLINT_BASE = 32'h2000_0c00;
    localparam logic [31:0] CLINT_MASK = 32'hffff_ff00;

    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);
    localparam int GPIO_W     = 32;

    // register offsets within a 256 byte peripheral window
    localparam logic [7:0] GPIO_OUT_OFS    = 8'h00;
    localparam logic [7:0] GPIO_IN_OFS     = 8'h04;
    localparam logic [7:0] CLINT_MTIME_OFS = 8'h00;
    localparam logic [7:0] CLINT_CMP_OFS   = 8'h08;

    // replace only the bytes enabled in sel
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0]  sel);
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) res[b*8 +: 8] = new_val[b*8 +: 8];
        end
        return res;
    endfunction

endpackage

// File: rtl/wb_mux.sv
`timescale 1ns/100ps

module wb_mux
    import wb_pkg::*;
(
    input  logic                       wb_clk_i,
    input  logic                       rst_i,

    input  wb_req_t                    wbm_req_i,
    output wb_rsp_t                    wbm_rsp_o,

    output wb_req_t [NUM_SLAVES-1:0]   wbs_req_o,
    input  wb_rsp_t [NUM_SLAVES-1:0]   wbs_rsp_i
);

    logic [NUM_SLAVES-1:0] slv_sel;
    logic                  hit;
    logic                  req_valid;
    logic                  err_q;
    wb_rsp_t               slv_rsp;

    assign req_valid = wbm_req_i.cyc & wbm_req_i.stb;

    // one-hot decode against the package map
    always_comb begin
        slv_sel            = '0;
        slv_sel[SLV_DMEM]  = (wbm_req_i.adr & DMEM_MASK)  == DMEM_BASE;
        slv_sel[SLV_GPIO]  = (wbm_req_i.adr & GPIO_MASK)  == GPIO_BASE;
        slv_sel[SLV_CLINT] = (wbm_req_i.adr & CLINT_MASK) == CLINT_BASE;
    end

    assign hit = |slv_sel;

    // only the selected slave sees cyc and stb
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            wbs_req_o[i]     = wbm_req_i;
            wbs_req_o[i].cyc = wbm_req_i.cyc & slv_sel[i];
            wbs_req_o[i].stb = wbm_req_i.stb & slv_sel[i];
        end
    end

    // select is one-hot so or-ing the gated responses is enough
    // a miss leaves the response at zero
    always_comb begin
        slv_rsp = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (slv_sel[i]) begin
                slv_rsp.dat = slv_rsp.dat | wbs_rsp_i[i].dat;
                slv_rsp.ack = slv_rsp.ack | wbs_rsp_i[i].ack;
                slv_rsp.err = slv_rsp.err | wbs_rsp_i[i].err;
            end
        end
    end

    // one registered err pulse per unmapped request
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req_valid & ~hit & ~err_q;
        end
    end

    always_comb begin
        wbm_rsp_o     = slv_rsp;
        wbm_rsp_o.err = slv_rsp.err | err_q;
    end

endmodule

// File: rtl/wb_dmem.sv
`timescale 1ns/100ps

module wb_dmem
    import wb_pkg::*;
(
    input  logic    wb_clk_i,
    input  logic    rst_i,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o
);

    logic [31:0]        mem [DMEM_WORDS];
    logic [31:0]        rdata_q;
    logic               ack_q;
    logic               access;
    logic [DMEM_AW-1:0] word_idx;

    // upper region bits alias onto the same words
    assign word_idx = req_i.adr[DMEM_AW+1:2];
    assign access   = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // byte lane writes
    always_ff @(posedge wb_clk_i) begin
        if (access && req_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.sel[b]) begin
                    mem[word_idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access && !req_i.we) begin
            rdata_q <= mem[word_idx];
        end
    end

    assign rsp_o.dat = rdata_q;
    assign rsp_o.ack = ack_q;
    assign rsp_o.err = 1'b0;

endmodule

// File: rtl/wb_gpio.sv
`timescale 1ns/100ps

module wb_gpio
    import wb_pkg::*;
(
    input  logic              wb_clk_i,
    input  logic              rst_i,
    input  wb_req_t           req_i,
    output wb_rsp_t           rsp_o,
    input  logic [GPIO_W-1:0] gpio_i,
    output logic [GPIO_W-1:0] gpio_o
);

    logic [GPIO_W-1:0] out_q;
    logic [GPIO_W-1:0] in_meta_q;
    logic [GPIO_W-1:0] in_sync_q;
    logic [31:0]       rdata_q;
    logic              ack_q;
    logic              access;
    logic [7:0]        ofs;

    assign access = req_i.cyc & req_i.stb & ~ack_q;
    assign ofs    = req_i.adr[7:0];

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            out_q <= '0;
        end else begin
            ack_q <= access;
            if (access && req_i.we && ofs == GPIO_OUT_OFS) begin
                out_q <= merge_bytes(out_q, req_i.dat, req_i.sel);
            end
        end
    end

    // two flop synchronizer for the pins
    always_ff @(posedge wb_clk_i) begin
        in_meta_q <= gpio_i;
        in_sync_q <= in_meta_q;
    end

    always_ff @(posedge wb_clk_i) begin
        if (access && !req_i.we) begin
            case (ofs)
                GPIO_OUT_OFS: rdata_q <= out_q;
                GPIO_IN_OFS:  rdata_q <= in_sync_q;
                default:      rdata_q <= '0;
            endcase
        end
    end

    assign gpio_o    = out_q;
    assign rsp_o.dat = rdata_q;
    assign rsp_o.ack = ack_q;
    assign rsp_o.err = 1'b0;

endmodule

// File: rtl/wb_clint.sv
`timescale 1ns/100ps

module wb_clint
    import wb_pkg::*;
(
    input  logic    wb_clk_i,
    input  logic    rst_i,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o,
    output logic    timer_irq_o
);

    logic [31:0] mtime_q;
    logic [31:0] mtimecmp_q;
    logic [31:0] rdata_q;
    logic        irq_q;
    logic        ack_q;
    logic        access;
    logic        wr;
    logic [7:0]  ofs;

    assign access = req_i.cyc & req_i.stb & ~ack_q;
    assign wr     = access & req_i.we;
    assign ofs    = req_i.adr[7:0];

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q      <= 1'b0;
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            irq_q      <= 1'b0;
        end else begin
            ack_q <= access;

            // a write to mtime replaces this cycle's increment
            if (wr && ofs == CLINT_MTIME_OFS) begin
                mtime_q <= merge_bytes(mtime_q, req_i.dat, req_i.sel);
            end else begin
                mtime_q <= mtime_q + 32'd1;
            end

            if (wr && ofs == CLINT_CMP_OFS) begin
                mtimecmp_q <= merge_bytes(mtimecmp_q, req_i.dat, req_i.sel);
            end

            // compare lags the counter by one cycle
            irq_q <= (mtime_q >= mtimecmp_q);
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access && !req_i.we) begin
            case (ofs)
                CLINT_MTIME_OFS: rdata_q <= mtime_q;
                CLINT_CMP_OFS:   rdata_q <= mtimecmp_q;
                default:         rdata_q <= '0;
            endcase
        end
    end

    assign timer_irq_o = irq_q;
    assign rsp_o.dat   = rdata_q;
    assign rsp_o.ack   = ack_q;
    assign rsp_o.err   = 1'b0;

endmodule

// File: rtl/wb_intercon.sv
`timescale 1ns/100ps

module wb_intercon
    import wb_pkg::*;
(
    input  logic              wb_clk_i,
    input  logic              rst_i,

    // data port master
    input  wb_req_t           wbm_req_i,
    output wb_rsp_t           wbm_rsp_o,

    // pins
    input  logic [GPIO_W-1:0] gpio_i,
    output logic [GPIO_W-1:0] gpio_o,
    output logic              timer_irq_o
);

    wb_req_t [NUM_SLAVES-1:0] slv_req;
    wb_rsp_t [NUM_SLAVES-1:0] slv_rsp;

    wb_mux u_wb_mux (
        .wb_clk_i  (wb_clk_i),
        .rst_i     (rst_i),
        .wbm_req_i (wbm_req_i),
        .wbm_rsp_o (wbm_rsp_o),
        .wbs_req_o (slv_req),
        .wbs_rsp_i (slv_rsp)
    );

    wb_dmem u_wb_dmem (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .req_i    (slv_req[SLV_DMEM]),
        .rsp_o    (slv_rsp[SLV_DMEM])
    );

    wb_gpio u_wb_gpio (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .req_i    (slv_req[SLV_GPIO]),
        .rsp_o    (slv_rsp[SLV_GPIO]),
        .gpio_i   (gpio_i),
        .gpio_o   (gpio_o)
    );

    // machine timer
    wb_clint u_wb_clint (
        .wb_clk_i    (wb_clk_i),
        .rst_i       (rst_i),
        .req_i       (slv_req[SLV_CLINT]),
        .rsp_o       (slv_rsp[SLV_CLINT]),
        .timer_irq_o (timer_irq_o)
    );

endmodule

// File: testbench/tb_wb_intercon.sv
`timescale 1ns/100ps

module tb_wb_intercon
    import wb_pkg::*;
();

    // the tests take roughly 1000 cycles and the limit is four times that
    localparam int EST_CYCLES     = 1000;
    localparam int TIMEOUT_CYCLES = 4 * EST_CYCLES;
    localparam logic [31:0] GPIO_OUT_ADR  = GPIO_BASE | 32'(GPIO_OUT_OFS);
    localparam logic [31:0] GPIO_IN_ADR   = GPIO_BASE | 32'(GPIO_IN_OFS);
    localparam logic [31:0] MTIME_ADR     = CLINT_BASE | 32'(CLINT_MTIME_OFS);
    localparam logic [31:0] MTIMECMP_ADR  = CLINT_BASE | 32'(CLINT_CMP_OFS);

    logic              clk;
    logic              rst;
    wb_req_t           wbm_req;
    wb_rsp_t           wbm_rsp;
    logic [GPIO_W-1:0] gpio_in;
    logic [GPIO_W-1:0] gpio_out;
    logic              timer_irq;

    logic [31:0] ref_mem [DMEM_WORDS];
    logic [31:0] ref_gpio;
    logic [31:0] lfsr_state;
    int          errors;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    int          cycle_cnt;

    wb_intercon u_wb_intercon (
        .wb_clk_i    (clk),
        .rst_i       (rst),
        .wbm_req_i   (wbm_req),
        .wbm_rsp_o   (wbm_rsp),
        .gpio_i      (gpio_in),
        .gpio_o      (gpio_out),
        .timer_irq_o (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // wishbone classic rules seen at the master port
    a_one_cycle: assert property (@(posedge clk) disable iff (rst)
        $rose(wbm_req.cyc & wbm_req.stb) |=> (wbm_rsp.ack | wbm_rsp.err))
    else begin
        $display("bus rule broken at %0t: no response one cycle after stb", $time);
        errors++;
    end

    a_ack_err: assert property (@(posedge clk) disable iff (rst)
        !(wbm_rsp.ack && wbm_rsp.err))
    else begin
        $display("bus rule broken at %0t: ack and err high together", $time);
        errors++;
    end

    a_no_stb: assert property (@(posedge clk) disable iff (rst)
        (wbm_rsp.ack | wbm_rsp.err) |-> $past(wbm_req.cyc & wbm_req.stb))
    else begin
        $display("bus rule broken at %0t: response without a request", $time);
        errors++;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] mask_merge(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  sel);
        logic [31:0] mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp)
        else begin
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // one classic transfer with the request held until ack or err
    task automatic wb_access(input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, input logic we,
                             output logic [31:0] rdata, output logic got_err);
        int edges;
        edges = 0;
        @(posedge clk);
        wbm_req <= '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
        do begin
            @(posedge clk);
            edges++;
        end while (!(wbm_rsp.ack || wbm_rsp.err));
        rdata   = wbm_rsp.dat;
        got_err = wbm_rsp.err;
        wbm_req <= '0;
        // the first edge only sees stb and the response is due at the next one
        check_value("response latency", 32'd1, 32'(edges - 1));
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic exp_err);
        logic [31:0] rdata;
        logic        got_err;
        wb_access(adr, dat, sel, 1'b1, rdata, got_err);
        check_value("wbm_rsp_o.err", 32'(exp_err), 32'(got_err));
    endtask

    task automatic wb_read(input logic [31:0] adr, input logic exp_err,
                           output logic [31:0] rdata);
        logic got_err;
        wb_access(adr, '0, 4'hf, 1'b0, rdata, got_err);
        check_value("wbm_rsp_o.err", 32'(exp_err), 32'(got_err));
    endtask

    task automatic read_expect(input logic [31:0] adr, input logic [31:0] exp,
                               input string name);
        logic [31:0] rdata;
        wb_read(adr, 1'b0, rdata);
        check_value(name, exp, rdata);
    endtask

    task automatic unmapped_access(input logic [31:0] adr);
        logic [31:0] dat;
        logic [31:0] rdata;
        rand_bits(32, dat);
        wb_write(adr, dat, 4'hf, 1'b1);
        // same hole at the mtimecmp offset
        wb_write(adr | 32'(CLINT_CMP_OFS), dat, 4'hf, 1'b1);
        wb_read(adr, 1'b1, rdata);
        check_value("wbm_rsp_o.dat", 32'd0, rdata);
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            tests_passed++;
            $display("[%0t] %s: pass", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s: FAIL, %0d errors", $time, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] adr;
        logic [31:0] dat;
        logic [31:0] sel;
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] wr_adr [32];
        rst          <= 1'b1;
        wbm_req      <= '0;
        gpio_in      <= '0;
        lfsr_state   = 32'd60;
        errors       = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        check_value("wbm_rsp_o.ack", 32'd0, 32'(wbm_rsp.ack));
        check_value("wbm_rsp_o.err", 32'd0, 32'(wbm_rsp.err));
        check_value("timer_irq_o", 32'd0, 32'(timer_irq));
        check_value("gpio_o", 32'd0, gpio_out);
        read_expect(MTIMECMP_ADR, 32'hffff_ffff, "mtimecmp");
        end_test("reset state");

        // fill every word so partial writes land on known data
        for (int i = 0; i < DMEM_WORDS; i++) begin
            adr = DMEM_BASE | 32'(i << 2);
            ref_mem[i] = (adr * 32'h9e37_79b1) ^ 32'h3c3c_a5a5;
            wb_write(adr, ref_mem[i], 4'hf, 1'b0);
        end
        for (int i = 0; i < 32; i++) begin
            rand_bits(16, dat);
            wr_adr[i] = DMEM_BASE | {14'd0, dat[15:0], 2'b00};
            rand_bits(32, dat);
            rand_bits(4, sel);
            ref_mem[wr_adr[i][9:2]] = mask_merge(ref_mem[wr_adr[i][9:2]], dat, sel[3:0]);
            wb_write(wr_adr[i], dat, sel[3:0], 1'b0);
        end
        for (int i = 0; i < 32; i++) begin
            // read back through another alias of the same word
            rand_bits(8, dat);
            adr = {wr_adr[i][31:18], dat[7:0], wr_adr[i][9:0]};
            read_expect(adr, ref_mem[adr[9:2]], "dmem read data");
        end
        end_test("data memory");

        rand_bits(32, dat);
        ref_gpio = dat;
        wb_write(GPIO_OUT_ADR, dat, 4'hf, 1'b0);
        @(posedge clk);
        check_value("gpio_o", ref_gpio, gpio_out);
        rand_bits(32, dat);
        ref_gpio = mask_merge(ref_gpio, dat, 4'b0101);
        wb_write(GPIO_OUT_ADR, dat, 4'b0101, 1'b0);
        read_expect(GPIO_OUT_ADR, ref_gpio, "gpio out readback");
        check_value("gpio_o", ref_gpio, gpio_out);
        rand_bits(32, dat);
        gpio_in <= dat;
        repeat (3) @(posedge clk);
        read_expect(GPIO_IN_ADR, dat, "gpio in readback");
        end_test("gpio");

        wb_read(MTIME_ADR, 1'b0, t1);
        repeat (10) @(posedge clk);
        wb_read(MTIME_ADR, 1'b0, t2);
        assert (t2 - t1 >= 32'd10)
        else begin
            $display("mtime advanced only %0d over more than 10 cycles", t2 - t1);
            errors++;
        end
        wb_read(MTIME_ADR, 1'b0, t1);
        wb_write(MTIMECMP_ADR, t1 + 32'd20, 4'hf, 1'b0);
        // mtime was sampled four edges before the write returned
        // so the irq rises at the sixteenth edge from here and reads high after it
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            check_value("timer_irq_o", 32'd0, 32'(timer_irq));
        end
        repeat (9) @(posedge clk);
        check_value("timer_irq_o", 32'd1, 32'(timer_irq));
        wb_write(MTIMECMP_ADR, 32'hffff_ffff, 4'hf, 1'b0);
        repeat (2) @(posedge clk);
        check_value("timer_irq_o", 32'd0, 32'(timer_irq));
        end_test("timer");

        unmapped_access(32'h0000_0000);
        unmapped_access(32'h4000_0000);
        unmapped_access(32'h2000_0200);
        // word 0 and word 0x80 share low address bits with the holes
        read_expect(DMEM_BASE, ref_mem[0], "dmem word 0");
        read_expect(DMEM_BASE | 32'h200, ref_mem[8'h80], "dmem word 0x80");
        read_expect(GPIO_OUT_ADR, ref_gpio, "gpio out readback");
        read_expect(MTIMECMP_ADR, 32'hffff_ffff, "mtimecmp");
        end_test("unmapped addresses");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src.f
rtl/wb_pkg.sv
rtl/wb_mux.sv
rtl/wb_dmem.sv
rtl/wb_gpio.sv
rtl/wb_clint.sv
rtl/wb_intercon.sv
testbench/tb_wb_intercon.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the wishbone fabric testbench with verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_wb_intercon -f src.f -o tb_wb_intercon \
    && ./obj_dir/tb_wb_intercon > sim.log 2>&1 \
    || { echo "build or run of the simulation failed"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "RESULT: FAIL (see sim.log)"; exit 1; }
echo "RESULT: PASS"
exit 0
